// File: Makefile
VERILATOR ?= verilator
TOP       ?= int_pipe_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// File: src/exec_stage.sv
module exec_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  pipe_pkg::id_ex_t   id_ex,
    input  pipe_pkg::fwd_sel_e fwd_a,
    input  pipe_pkg::fwd_sel_e fwd_b,
    output pipe_pkg::ex_mem_t  ex_mem,
    input  pipe_pkg::mem_wb_t  mem_wb
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    xword_t  op_a;
    xword_t  op_b;
    xword_t  imm_x;
    xword_t  alu_res;
    ex_mem_t ex_mem_d;

    function automatic xword_t fwd_mux(fwd_sel_e sel, xword_t rf_val, xword_t em_val,
                                       xword_t mw_val);
        case (sel)
            fwd_ex_mem: return em_val;
            fwd_mem_wb: return mw_val;
            default:    return rf_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, id_ex.rs1_val, ex_mem.result, mem_wb.value);
    assign op_b  = fwd_mux(fwd_b, id_ex.rs2_val, ex_mem.result, mem_wb.value);
    assign imm_x = {{(xlen - $bits(imm_t)){id_ex.imm[$bits(imm_t)-1]}}, id_ex.imm};

    always_comb begin
        case (id_ex.op)
            op_add:  alu_res = op_a + op_b;
            op_sub:  alu_res = op_a - op_b;
            op_and:  alu_res = op_a & op_b;
            op_or:   alu_res = op_a | op_b;
            op_xor:  alu_res = op_a ^ op_b;
            default: alu_res = op_a + imm_x;        // addi and ld/sd address
        endcase
    end

    always_comb begin
        ex_mem_d.valid      = id_ex.valid;
        ex_mem_d.op         = id_ex.op;
        ex_mem_d.rd         = id_ex.rd;
        ex_mem_d.wen        = id_ex.wen;
        ex_mem_d.result     = alu_res;
        ex_mem_d.store_data = op_b;                  // forwarded rs2
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_mem_d;
        end
    end

endmodule

// File: src/hazard_unit.sv
module hazard_unit (
    input  logic               issue_valid,
    input  pipe_pkg::issue_t   issue,
    input  pipe_pkg::id_ex_t   id_ex,
    input  pipe_pkg::ex_mem_t  ex_mem,
    input  pipe_pkg::mem_wb_t  mem_wb,
    output logic               stall,
    output pipe_pkg::fwd_sel_e fwd_a,
    output pipe_pkg::fwd_sel_e fwd_b
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic load_in_ex;
    logic rs1_hit;
    logic rs2_hit;

    // youngest producer wins, a load in EX/MEM has no data yet
    function automatic fwd_sel_e pick_source(reg_idx_t src, ex_mem_t em, mem_wb_t mw);
        fwd_sel_e sel;
        sel = fwd_none;
        if (src != '0) begin
            if (em.valid && em.wen && (em.rd == src) && (em.op != op_ld)) begin
                sel = fwd_ex_mem;
            end else if (mw.valid && mw.wen && (mw.rd == src)) begin
                sel = fwd_mem_wb;
            end
        end
        return sel;
    endfunction

    // ------------------------------------------------------------------------
    // load-use detection against the offered op
    // ------------------------------------------------------------------------

    assign load_in_ex = id_ex.valid && (id_ex.op == op_ld) && (id_ex.rd != '0);

    assign rs1_hit = (issue.rs1 == id_ex.rd);        // rs1 always read
    assign rs2_hit = reads_rs2(issue.op) && (issue.rs2 == id_ex.rd);

    // one cycle only, the load leaves ID/EX at the next edge
    assign stall = issue_valid && load_in_ex && (rs1_hit || rs2_hit);

    // ------------------------------------------------------------------------
    // operand source selects for the op now in ID/EX
    // ------------------------------------------------------------------------

    assign fwd_a = pick_source(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = pick_source(id_ex.rs2, ex_mem, mem_wb);

endmodule

// File: src/int_pipe_top.sv
module int_pipe_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    input  pipe_pkg::issue_t  issue,
    output logic              issue_ready,
    output logic              retire_valid,
    output pipe_pkg::retire_t retire
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xword_t   rs1_data;
    xword_t   rs2_data;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    logic     stall;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    issue_stage u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .stall       (stall),
        .issue_ready (issue_ready),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id_ex       (id_ex)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr       (mem_wb)                           // WB write port
    );

    hazard_unit u_hazard (
        .issue_valid (issue_valid),
        .issue       (issue),
        .id_ex       (id_ex),
        .ex_mem      (ex_mem),
        .mem_wb      (mem_wb),
        .stall       (stall),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

    exec_stage u_exec (
        .clk    (clk),
        .rst_n  (rst_n),
        .id_ex  (id_ex),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb)
    );

    mem_stage u_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb)
    );

    assign retire_valid = mem_wb.valid;
    assign retire       = '{rd: mem_wb.rd, wen: mem_wb.wen, value: mem_wb.value};

endmodule

// File: src/issue_stage.sv
module issue_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  pipe_pkg::issue_t     issue,
    input  logic                 stall,
    output logic                 issue_ready,
    output rv_isa_pkg::reg_idx_t rs1_idx,
    output rv_isa_pkg::reg_idx_t rs2_idx,
    input  rv_isa_pkg::xword_t   rs1_data,
    input  rv_isa_pkg::xword_t   rs2_data,
    output pipe_pkg::id_ex_t     id_ex
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic   take;
    id_ex_t id_ex_d;

    assign issue_ready = !stall;
    assign take        = issue_valid && issue_ready;

    // register read runs off the offered op, even before acceptance
    assign rs1_idx = issue.rs1;
    assign rs2_idx = issue.rs2;

    // ------------------------------------------------------------------------
    // next ID/EX contents
    // ------------------------------------------------------------------------

    always_comb begin
        id_ex_d.valid   = take;                      // bubble on stall or idle
        id_ex_d.op      = issue.op;
        id_ex_d.rs1     = issue.rs1;
        id_ex_d.rs2     = issue.rs2;
        id_ex_d.rd      = issue.rd;
        id_ex_d.imm     = issue.imm;
        id_ex_d.rs1_val = rs1_data;
        id_ex_d.rs2_val = rs2_data;

        // writes to x0 are dropped here, so later stages never see them
        id_ex_d.wen = take && writes_rd(issue.op) && (issue.rd != '0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

// File: src/mem_stage.sv
module mem_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::mem_wb_t mem_wb
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    xword_t    dmem [dmem_depth];
    dmem_idx_t idx;
    xword_t    rdata;
    mem_wb_t   mem_wb_d;

    // upper address bits dropped, wraps every 512 bytes
    assign idx   = ex_mem.result[dmem_lsb +: $bits(dmem_idx_t)];
    assign rdata = dmem[idx];

    // ------------------------------------------------------------------------
    // data memory
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && (ex_mem.op == op_sd)) begin
            dmem[idx] <= ex_mem.store_data;
        end
    end

    // ------------------------------------------------------------------------
    // MEM/WB register
    // ------------------------------------------------------------------------

    always_comb begin
        mem_wb_d.valid = ex_mem.valid;
        mem_wb_d.rd    = ex_mem.rd;
        mem_wb_d.wen   = ex_mem.wen;
        case (ex_mem.op)
            op_ld:   mem_wb_d.value = rdata;
            op_sd:   mem_wb_d.value = ex_mem.store_data;
            default: mem_wb_d.value = ex_mem.result;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= mem_wb_d;
        end
    end

endmodule

// File: src/pipe_pkg.sv
package pipe_pkg;
    import rv_isa_pkg::*;

    localparam int dmem_depth = 64;
    localparam int dmem_lsb   = 3;                   // byte offset inside a doubleword

    typedef logic [$clog2(dmem_depth)-1:0] dmem_idx_t;

    // ------------------------------------------------------------------------
    // stage registers
    // ------------------------------------------------------------------------

    typedef struct packed {
        uop_e     op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        imm_t     imm;
    } issue_t;

    typedef struct packed {
        logic     valid;
        uop_e     op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     wen;
        imm_t     imm;
        xword_t   rs1_val;
        xword_t   rs2_val;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        uop_e     op;
        reg_idx_t rd;
        logic     wen;
        xword_t   result;                            // effective address for ld/sd
        xword_t   store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     wen;
        xword_t   value;                             // store data for sd
    } mem_wb_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     wen;
        xword_t   value;
    } retire_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_ex_mem,
        fwd_mem_wb
    } fwd_sel_e;

endpackage

// File: src/reg_file.sv
module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_isa_pkg::reg_idx_t rs1_idx,
    input  rv_isa_pkg::reg_idx_t rs2_idx,
    output rv_isa_pkg::xword_t   rs1_data,
    output rv_isa_pkg::xword_t   rs2_data,
    input  pipe_pkg::mem_wb_t    wr
);
    import rv_isa_pkg::*;

    xword_t regs [reg_count];
    logic   wr_en;

    assign wr_en = wr.valid && wr.wen && (wr.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.value;
        end
    end

    // write-through so WB and the issue read can share a cycle
    assign rs1_data = (rs1_idx == '0)                ? '0       :
                      (wr_en && (wr.rd == rs1_idx)) ? wr.value :
                                                      regs[rs1_idx];

    assign rs2_data = (rs2_idx == '0)                ? '0       :
                      (wr_en && (wr.rd == rs2_idx)) ? wr.value :
                                                      regs[rs2_idx];

endmodule

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen      = 64;
    localparam int reg_count = 32;

    typedef logic [xlen-1:0]              xword_t;
    typedef logic [$clog2(reg_count)-1:0] reg_idx_t;
    typedef logic [31:0]                  imm_t;     // already sign-extended by decode

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_ld,
        op_sd
    } uop_e;

    // every op reads rs1, only R-type and sd read rs2
    function automatic logic reads_rs2(uop_e op);
        return op inside {op_add, op_sub, op_and, op_or, op_xor, op_sd};
    endfunction

    function automatic logic writes_rd(uop_e op);
        return op != op_sd;
    endfunction

endpackage

// File: verif/int_pipe_chk.sv
module int_pipe_chk (
    input logic              clk,
    input logic              rst_n,
    input logic              issue_valid,
    input pipe_pkg::issue_t  issue,
    input logic              issue_ready,
    input logic              retire_valid,
    input pipe_pkg::retire_t retire
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    typedef struct packed {
        logic    valid;
        retire_t data;
    } expect_t;

    xword_t      mregs [reg_count];
    xword_t      mmem [dmem_depth];
    expect_t     expect_q [3];                       // one slot per cycle to retire
    logic        xfer;
    logic        ld_pending;
    reg_idx_t    ld_rd;
    logic        exp_stall;
    xword_t      src_a;
    xword_t      src_b;
    xword_t      addr;
    retire_t     exp_ret;
    int unsigned err_count = 0;

    assign xfer  = issue_valid && issue_ready;
    assign src_a = (issue.rs1 == '0) ? '0 : mregs[issue.rs1];
    assign src_b = (issue.rs2 == '0) ? '0 : mregs[issue.rs2];
    assign addr  = src_a + {{32{issue.imm[31]}}, issue.imm};

    // ------------------------------------------------------------------------
    // in-order reference model, executes each op at its transfer edge
    // ------------------------------------------------------------------------

    always_comb begin
        exp_ret.rd  = issue.rd;
        exp_ret.wen = (issue.op != op_sd) && (issue.rd != '0);
        case (issue.op)
            op_add:  exp_ret.value = src_a + src_b;
            op_sub:  exp_ret.value = src_a - src_b;
            op_and:  exp_ret.value = src_a & src_b;
            op_or:   exp_ret.value = src_a | src_b;
            op_xor:  exp_ret.value = src_a ^ src_b;
            op_ld:   exp_ret.value = mmem[addr[8:3]];
            op_sd:   exp_ret.value = src_b;
            default: exp_ret.value = addr;           // addi
        endcase
    end

    // load sitting in ID/EX against the offered op
    assign exp_stall = issue_valid && ld_pending && ((issue.rs1 == ld_rd) ||
                       ((issue.op inside {op_add, op_sub, op_and, op_or, op_xor, op_sd}) &&
                        (issue.rs2 == ld_rd)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mregs      <= '{default: '0};
            mmem       <= '{default: '0};
            expect_q   <= '{default: '0};
            ld_pending <= 1'b0;
            ld_rd      <= '0;
        end else begin
            expect_q[0] <= '{valid: xfer, data: exp_ret};
            expect_q[1] <= expect_q[0];
            expect_q[2] <= expect_q[1];
            ld_pending  <= xfer && (issue.op == op_ld) && (issue.rd != '0);
            ld_rd       <= issue.rd;
            if (xfer && exp_ret.wen) begin
                mregs[issue.rd] <= exp_ret.value;
            end
            if (xfer && (issue.op == op_sd)) begin
                mmem[addr[8:3]] <= src_b;
            end
        end
    end

    // ------------------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------------------

    a_reset_idle: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (!retire_valid && issue_ready))
        else begin
            err_count++;
            $error("FAIL retire_valid %h issue_ready %h at reset",
                   $sampled(retire_valid), $sampled(issue_ready));
        end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        issue_ready == !exp_stall)
        else begin
            err_count++;
            $error("FAIL issue_ready: got %h expected %h",
                   $sampled(issue_ready), !$sampled(exp_stall));
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid == expect_q[2].valid)
        else begin
            err_count++;
            $error("FAIL retire_valid: got %h expected %h",
                   $sampled(retire_valid), $sampled(expect_q[2].valid));
        end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        expect_q[2].valid |-> (retire == expect_q[2].data))
        else begin
            err_count++;
            $error("FAIL retire: got %h expected %h",
                   $sampled(retire), $sampled(expect_q[2].data));
        end

endmodule

bind int_pipe_top int_pipe_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .issue_ready  (issue_ready),
    .retire_valid (retire_valid),
    .retire       (retire)
);

// File: verif/int_pipe_tb.sv
module int_pipe_tb;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int n_ops          = 400;
    localparam int timeout_cycles = n_ops * 4 + 200;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    issue_valid;
    issue_t  issue;
    logic    issue_ready;
    logic    retire_valid;
    retire_t retire;
    int      seed;
    int      retired = 0;

    int_pipe_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            retired <= retired + 1;                  // stable by the falling edge
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic offer_random_op();
        issue_t op;
        logic   accepted;
        op.op  = uop_e'($random(seed) & 7);
        op.rs1 = reg_idx_t'($random(seed) & 7);      // x0..x7, dense dependencies
        op.rs2 = reg_idx_t'($random(seed) & 7);
        op.rd  = reg_idx_t'($random(seed) & 7);
        if (op.op inside {op_ld, op_sd}) begin
            op.imm = imm_t'(($random(seed) & 63) << 3);
        end else begin
            op.imm = imm_t'($random(seed) % 64);
        end
        issue_valid = 1'b1;
        issue       = op;
        accepted    = 1'b0;
        while (!accepted) begin
            #1;
            accepted = issue_ready;                  // transfer at the coming edge
            @(negedge clk);
        end
        issue_valid = 1'b0;
    endtask

    initial begin
        seed        = 29469;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            if (($random(seed) & 7) == 0) begin
                issue_valid = 1'b0;                  // idle cycle
                @(negedge clk);
            end
            offer_random_op();
        end
        wait (retired == n_ops);
        repeat (2) @(negedge clk);
        if (i_dut.u_chk.err_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "assertion errors recorded");
        end
    end

    // ------------------------------------------------------------------------
    // failure paths
    // ------------------------------------------------------------------------

    initial begin
        wait (i_dut.u_chk.err_count != 0);
        $display("Testbench failed");
        $fatal(1, "assertion failure, see FAIL line above");
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: instructions did not all retire");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verilog.f
src/rv_isa_pkg.sv
src/pipe_pkg.sv
src/reg_file.sv
src/hazard_unit.sv
src/issue_stage.sv
src/exec_stage.sv
src/mem_stage.sv
src/int_pipe_top.sv
verif/int_pipe_chk.sv
verif/int_pipe_tb.sv
